//--- rv32i_config.svh
`ifndef RV32I_CONFIG_SVH
`define RV32I_CONFIG_SVH

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// younger instructions lost on a taken branch or jump in MEM
// (the ones in ID and EX, plus the sequential fetch that the target replaces)
`define SQUASH_DEPTH 3

// log2 of the testbench memory size in bytes
`define MEM_ADDR_BITS 12

`endif

//--- rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  reg_idx;
    typedef logic [6:0]  rv32i_opcode;
    typedef logic [2:0]  funct3_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [3:0]  byte_mask;

    // decoded control carried down ID/EX, EX/MEM and MEM/WB
    typedef struct packed {
        alu_op_t    alu_op;
        logic       alu_sub;
        funct3_t    cmp_op;
        logic       alumux1_sel;
        logic [2:0] alumux2_sel;
        logic [2:0] regfile_mux_sel;
        logic       load_regfile;
        reg_idx     dest;
        logic       mem_read;
        logic       mem_write;
        funct3_t    mem_size;
        logic       is_branch;
        logic       is_jump;
        logic       is_jalr;
        logic       valid;
    } ctrl_word_t;

    // alu ops follow the funct3 encoding of the OP group
    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SLL  = 3'd1;
    localparam alu_op_t ALU_SLT  = 3'd2;
    localparam alu_op_t ALU_SLTU = 3'd3;
    localparam alu_op_t ALU_XOR  = 3'd4;
    localparam alu_op_t ALU_SRL  = 3'd5;
    localparam alu_op_t ALU_OR   = 3'd6;
    localparam alu_op_t ALU_AND  = 3'd7;

    localparam logic ALUMUX1_RS1 = 1'b0;
    localparam logic ALUMUX1_PC  = 1'b1;

    localparam logic [2:0] ALUMUX2_I_IMM = 3'd0;
    localparam logic [2:0] ALUMUX2_U_IMM = 3'd1;
    localparam logic [2:0] ALUMUX2_B_IMM = 3'd2;
    localparam logic [2:0] ALUMUX2_S_IMM = 3'd3;
    localparam logic [2:0] ALUMUX2_J_IMM = 3'd4;
    localparam logic [2:0] ALUMUX2_RS2   = 3'd5;

    localparam logic [2:0] RFMUX_ALU      = 3'd0;
    localparam logic [2:0] RFMUX_BR_EN    = 3'd1;
    localparam logic [2:0] RFMUX_U_IMM    = 3'd2;
    localparam logic [2:0] RFMUX_LOAD     = 3'd3;
    localparam logic [2:0] RFMUX_PC_PLUS4 = 3'd4;

    localparam rv32i_opcode OP_LUI    = 7'b0110111;
    localparam rv32i_opcode OP_AUIPC  = 7'b0010111;
    localparam rv32i_opcode OP_JAL    = 7'b1101111;
    localparam rv32i_opcode OP_JALR   = 7'b1100111;
    localparam rv32i_opcode OP_BRANCH = 7'b1100011;
    localparam rv32i_opcode OP_LOAD   = 7'b0000011;
    localparam rv32i_opcode OP_STORE  = 7'b0100011;
    localparam rv32i_opcode OP_IMM    = 7'b0010011;
    localparam rv32i_opcode OP_REG    = 7'b0110011;

endpackage

//--- control_unit.sv
module control_unit (
    input  rv32i_pkg::rv32i_word  instr,
    output rv32i_pkg::ctrl_word_t ctrl_word
);
    import rv32i_pkg::*;

    rv32i_opcode opcode;
    funct3_t     funct3;
    logic        funct7_5;
    logic        is_slt;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7_5 = instr[30];
    assign is_slt   = (funct3 == ALU_SLT) || (funct3 == ALU_SLTU);

    always_comb begin
        ctrl_word                 = '0;
        ctrl_word.alu_op          = ALU_ADD;
        ctrl_word.alumux1_sel     = ALUMUX1_RS1;
        ctrl_word.alumux2_sel     = ALUMUX2_I_IMM;
        ctrl_word.regfile_mux_sel = RFMUX_ALU;
        ctrl_word.dest            = instr[11:7];
        ctrl_word.mem_size        = funct3;
        ctrl_word.cmp_op          = funct3;
        ctrl_word.valid           = 1'b1;

        case (opcode)
            OP_LUI: begin
                ctrl_word.load_regfile    = 1'b1;
                ctrl_word.regfile_mux_sel = RFMUX_U_IMM;
            end
            OP_AUIPC: begin
                ctrl_word.alumux1_sel  = ALUMUX1_PC;
                ctrl_word.alumux2_sel  = ALUMUX2_U_IMM;
                ctrl_word.load_regfile = 1'b1;
            end
            OP_JAL: begin
                ctrl_word.alumux1_sel     = ALUMUX1_PC;
                ctrl_word.alumux2_sel     = ALUMUX2_J_IMM;
                ctrl_word.load_regfile    = 1'b1;
                ctrl_word.regfile_mux_sel = RFMUX_PC_PLUS4;
                ctrl_word.is_jump         = 1'b1;
            end
            OP_JALR: begin
                ctrl_word.load_regfile    = 1'b1;
                ctrl_word.regfile_mux_sel = RFMUX_PC_PLUS4;
                ctrl_word.is_jump         = 1'b1;
                ctrl_word.is_jalr         = 1'b1;
            end
            OP_BRANCH: begin
                // alu forms the target, compare unit decides
                ctrl_word.alumux1_sel = ALUMUX1_PC;
                ctrl_word.alumux2_sel = ALUMUX2_B_IMM;
                ctrl_word.is_branch   = 1'b1;
            end
            OP_LOAD: begin
                ctrl_word.mem_read        = 1'b1;
                ctrl_word.load_regfile    = 1'b1;
                ctrl_word.regfile_mux_sel = RFMUX_LOAD;
            end
            OP_STORE: begin
                ctrl_word.alumux2_sel = ALUMUX2_S_IMM;
                ctrl_word.mem_write   = 1'b1;
            end
            OP_IMM, OP_REG: begin
                if (opcode == OP_REG) begin
                    ctrl_word.alumux2_sel = ALUMUX2_RS2;
                end
                ctrl_word.alu_op       = funct3;
                ctrl_word.alu_sub      = funct7_5 & ((funct3 == ALU_SRL) |
                                         ((opcode == OP_REG) & (funct3 == ALU_ADD)));
                ctrl_word.load_regfile = 1'b1;
                // slt and sltu go through the compare unit as blt and bltu
                if (is_slt) begin
                    ctrl_word.regfile_mux_sel = RFMUX_BR_EN;
                    ctrl_word.cmp_op          = {1'b1, funct3[0], 1'b0};
                end
            end
            default: begin
                ctrl_word.valid = 1'b0;
            end
        endcase
    end

endmodule

//--- regfile.sv
module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  rv32i_pkg::reg_idx    dest,
    input  rv32i_pkg::reg_idx    src_a,
    input  rv32i_pkg::reg_idx    src_b,
    input  rv32i_pkg::rv32i_word in,
    output rv32i_pkg::rv32i_word reg_a,
    output rv32i_pkg::rv32i_word reg_b
);
    import rv32i_pkg::*;

    rv32i_word regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load && dest != 5'd0) begin
            regs[dest] <= in;
        end
    end

    // a write in WB is visible to the read in ID of the same cycle
    function automatic rv32i_word read_port(reg_idx idx);
        rv32i_word val;
        val = regs[idx];
        if (load && idx == dest) begin
            val = in;
        end
        if (idx == 5'd0) begin
            val = '0;
        end
        return val;
    endfunction

    always_comb begin
        reg_a = read_port(src_a);
        reg_b = read_port(src_b);
    end

endmodule

//--- alu.sv
module alu (
    input  rv32i_pkg::alu_op_t   alu_op,
    input  logic                 alu_sub,
    input  rv32i_pkg::funct3_t   cmp_op,
    input  rv32i_pkg::rv32i_word a,
    input  rv32i_pkg::rv32i_word b,
    input  rv32i_pkg::rv32i_word cmp_a,
    input  rv32i_pkg::rv32i_word cmp_b,
    output rv32i_pkg::rv32i_word f,
    output logic                 br_en
);
    import rv32i_pkg::*;

    always_comb begin
        unique case (alu_op)
            ALU_ADD:  f = alu_sub ? a - b : a + b;
            ALU_SLL:  f = a << b[4:0];
            ALU_SLT:  f = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: f = {31'b0, a < b};
            ALU_XOR:  f = a ^ b;
            // alu_sub turns the right shift arithmetic
            ALU_SRL:  f = alu_sub ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            ALU_OR:   f = a | b;
            ALU_AND:  f = a & b;
        endcase
    end

    // branch funct3 encodings
    always_comb begin
        case (cmp_op)
            3'b000:  br_en = (cmp_a == cmp_b);
            3'b001:  br_en = (cmp_a != cmp_b);
            3'b100:  br_en = ($signed(cmp_a) < $signed(cmp_b));
            3'b101:  br_en = ($signed(cmp_a) >= $signed(cmp_b));
            3'b110:  br_en = (cmp_a < cmp_b);
            3'b111:  br_en = (cmp_a >= cmp_b);
            default: br_en = 1'b0;
        endcase
    end

endmodule

//--- datapath.sv
`include "rv32i_config.svh"

module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32i_pkg::rv32i_word inst_rdata,
    input  logic                 inst_resp,
    output rv32i_pkg::rv32i_word inst_addr,
    output logic                 inst_read,
    input  rv32i_pkg::rv32i_word data_rdata,
    input  logic                 data_resp,
    output rv32i_pkg::rv32i_word data_addr,
    output rv32i_pkg::rv32i_word data_wdata,
    output rv32i_pkg::byte_mask  data_mbe,
    output logic                 data_read,
    output logic                 data_write
);
    import rv32i_pkg::*;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word ir;
        logic      valid;
    } if_id_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv32i_word  pc;
        rv32i_word  ir;
        rv32i_word  rs1;
        rv32i_word  rs2;
    } id_ex_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv32i_word  pc;
        rv32i_word  alu;
        rv32i_word  rs2;
        rv32i_word  u_imm;
        logic       br_en;
    } ex_mem_t;

    typedef struct packed {
        ctrl_word_t ctrl;
        rv32i_word  pc;
        rv32i_word  alu;
        rv32i_word  u_imm;
        rv32i_word  rdata;
        logic       br_en;
    } mem_wb_t;

    if_id_t     if_id;
    id_ex_t     id_ex;
    ex_mem_t    ex_mem;
    mem_wb_t    mem_wb;
    rv32i_word  pc;
    rv32i_word  inst_buf;
    rv32i_word  data_buf;
    logic       inst_done;
    logic       data_done;
    rv32i_word  inst_word;
    rv32i_word  mem_rdata;
    logic       mem_req;
    logic       stall;
    logic       redirect;
    rv32i_word  target;
    ctrl_word_t dec_ctrl;
    ctrl_word_t id_ctrl;
    ctrl_word_t ex_ctrl;
    rv32i_word  rf_a;
    rv32i_word  rf_b;
    rv32i_word  i_imm;
    rv32i_word  s_imm;
    rv32i_word  b_imm;
    rv32i_word  u_imm;
    rv32i_word  j_imm;
    rv32i_word  alu_a;
    rv32i_word  alu_b;
    rv32i_word  cmp_b;
    rv32i_word  alu_f;
    logic       br_en;
    rv32i_word  load_word;
    rv32i_word  load_ext;
    rv32i_word  wb_data;

    // taken branch or jump in MEM steers the current fetch to the target
    assign redirect  = ex_mem.ctrl.valid &
                       (ex_mem.ctrl.is_jump | (ex_mem.ctrl.is_branch & ex_mem.br_en));
    assign target    = ex_mem.ctrl.is_jalr ? {ex_mem.alu[31:1], 1'b0} : ex_mem.alu;
    assign inst_addr = redirect ? target : pc;
    assign inst_read = 1'b1;

    assign mem_req    = ex_mem.ctrl.valid & (ex_mem.ctrl.mem_read | ex_mem.ctrl.mem_write);
    assign data_read  = ex_mem.ctrl.valid & ex_mem.ctrl.mem_read & ~data_done;
    assign data_write = ex_mem.ctrl.valid & ex_mem.ctrl.mem_write & ~data_done;
    assign data_addr  = {ex_mem.alu[31:2], 2'b00};
    assign data_wdata = ex_mem.rs2 << {ex_mem.alu[1:0], 3'b000};

    always_comb begin
        case (ex_mem.ctrl.mem_size[1:0])
            2'b00:   data_mbe = 4'b0001 << ex_mem.alu[1:0];
            2'b01:   data_mbe = 4'b0011 << ex_mem.alu[1:0];
            default: data_mbe = 4'b1111;
        endcase
    end

    // responses that arrive while the other port still waits are held here
    assign inst_word = inst_done ? inst_buf : inst_rdata;
    assign mem_rdata = data_done ? data_buf : data_rdata;
    assign stall     = (~inst_done & ~inst_resp) | (mem_req & ~data_done & ~data_resp);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_done <= 1'b0;
            data_done <= 1'b0;
        end else if (!stall) begin
            inst_done <= 1'b0;
            data_done <= 1'b0;
        end else begin
            if (inst_resp && !inst_done) begin
                inst_done <= 1'b1;
                inst_buf  <= inst_rdata;
            end
            if (mem_req && data_resp && !data_done) begin
                data_done <= 1'b1;
                data_buf  <= data_rdata;
            end
        end
    end

    control_unit u_control (
        .instr     (if_id.ir),
        .ctrl_word (dec_ctrl)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (mem_wb.ctrl.load_regfile & mem_wb.ctrl.valid),
        .dest  (mem_wb.ctrl.dest),
        .src_a (if_id.ir[19:15]),
        .src_b (if_id.ir[24:20]),
        .in    (wb_data),
        .reg_a (rf_a),
        .reg_b (rf_b)
    );

    // instructions in ID and EX are younger than a redirecting MEM op
    always_comb begin
        id_ctrl       = dec_ctrl;
        id_ctrl.valid = dec_ctrl.valid & if_id.valid & ~redirect;
        ex_ctrl       = id_ex.ctrl;
        ex_ctrl.valid = id_ex.ctrl.valid & ~redirect;
    end

    assign i_imm = {{21{id_ex.ir[31]}}, id_ex.ir[30:20]};
    assign s_imm = {{21{id_ex.ir[31]}}, id_ex.ir[30:25], id_ex.ir[11:7]};
    assign b_imm = {{20{id_ex.ir[31]}}, id_ex.ir[7], id_ex.ir[30:25], id_ex.ir[11:8], 1'b0};
    assign u_imm = {id_ex.ir[31:12], 12'h000};
    assign j_imm = {{12{id_ex.ir[31]}}, id_ex.ir[19:12], id_ex.ir[20], id_ex.ir[30:21], 1'b0};

    always_comb begin
        alu_a = (id_ex.ctrl.alumux1_sel == ALUMUX1_PC) ? id_ex.pc : id_ex.rs1;
        case (id_ex.ctrl.alumux2_sel)
            ALUMUX2_U_IMM: alu_b = u_imm;
            ALUMUX2_B_IMM: alu_b = b_imm;
            ALUMUX2_S_IMM: alu_b = s_imm;
            ALUMUX2_J_IMM: alu_b = j_imm;
            ALUMUX2_RS2:   alu_b = id_ex.rs2;
            default:       alu_b = i_imm;
        endcase
        // branches compare registers, slt compares against the second operand
        cmp_b = id_ex.ctrl.is_branch ? id_ex.rs2 : alu_b;
    end

    alu u_alu (
        .alu_op  (id_ex.ctrl.alu_op),
        .alu_sub (id_ex.ctrl.alu_sub),
        .cmp_op  (id_ex.ctrl.cmp_op),
        .a       (alu_a),
        .b       (alu_b),
        .cmp_a   (id_ex.rs1),
        .cmp_b   (cmp_b),
        .f       (alu_f),
        .br_en   (br_en)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc          <= `RESET_PC;
            if_id.valid <= 1'b0;
            id_ex.ctrl  <= '0;
            ex_mem.ctrl <= '0;
            mem_wb.ctrl <= '0;
        end else if (!stall) begin
            pc     <= inst_addr + 32'd4;
            if_id  <= '{pc: inst_addr, ir: inst_word, valid: 1'b1};
            id_ex  <= '{ctrl: id_ctrl, pc: if_id.pc, ir: if_id.ir, rs1: rf_a, rs2: rf_b};
            ex_mem <= '{ctrl: ex_ctrl, pc: id_ex.pc, alu: alu_f, rs2: id_ex.rs2,
                        u_imm: u_imm, br_en: br_en};
            mem_wb <= '{ctrl: ex_mem.ctrl, pc: ex_mem.pc, alu: ex_mem.alu,
                        u_imm: ex_mem.u_imm, rdata: mem_rdata, br_en: ex_mem.br_en};
        end
    end

    // move the addressed byte or half down to bit 0
    assign load_word = mem_wb.rdata >> {mem_wb.alu[1:0], 3'b000};

    always_comb begin
        case (mem_wb.ctrl.mem_size)
            3'b000:  load_ext = {{24{load_word[7]}}, load_word[7:0]};
            3'b001:  load_ext = {{16{load_word[15]}}, load_word[15:0]};
            3'b100:  load_ext = {24'h0, load_word[7:0]};
            3'b101:  load_ext = {16'h0, load_word[15:0]};
            default: load_ext = load_word;
        endcase
        case (mem_wb.ctrl.regfile_mux_sel)
            RFMUX_BR_EN:    wb_data = {31'b0, mem_wb.br_en};
            RFMUX_U_IMM:    wb_data = mem_wb.u_imm;
            RFMUX_LOAD:     wb_data = load_ext;
            RFMUX_PC_PLUS4: wb_data = mem_wb.pc + 32'd4;
            default:        wb_data = mem_wb.alu;
        endcase
    end

endmodule

//--- rv32i_core.sv
module rv32i_core (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32i_pkg::rv32i_word inst_rdata,
    input  logic                 inst_resp,
    output rv32i_pkg::rv32i_word inst_addr,
    output logic                 inst_read,
    input  rv32i_pkg::rv32i_word data_rdata,
    input  logic                 data_resp,
    output rv32i_pkg::rv32i_word data_addr,
    output rv32i_pkg::rv32i_word data_wdata,
    output rv32i_pkg::byte_mask  data_mbe,
    output logic                 data_read,
    output logic                 data_write
);

    // five-stage pipeline with separate instruction and data ports
    datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_rdata (inst_rdata),
        .inst_resp  (inst_resp),
        .inst_addr  (inst_addr),
        .inst_read  (inst_read),
        .data_rdata (data_rdata),
        .data_resp  (data_resp),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_mbe   (data_mbe),
        .data_read  (data_read),
        .data_write (data_write)
    );

endmodule

//--- tb_props.sv
`include "rv32i_config.svh"

module tb_props (
    input logic                 clk,
    input logic                 rst_n,
    input rv32i_pkg::rv32i_word inst_addr,
    input logic                 inst_read,
    input logic                 inst_resp,
    input rv32i_pkg::rv32i_word data_addr,
    input rv32i_pkg::rv32i_word data_wdata,
    input rv32i_pkg::byte_mask  data_mbe,
    input logic                 data_read,
    input logic                 data_write,
    input logic                 data_resp
);
    import rv32i_pkg::*;

    typedef struct packed {
        rv32i_word addr;
        rv32i_word data;
        byte_mask  mbe;
    } store_t;

    localparam int        NUM_STORES = 24;
    // program operands and data
    localparam rv32i_word A  = 32'd100;
    localparam rv32i_word B  = -32'sd7;
    localparam rv32i_word C  = 32'h1122_3344;
    localparam rv32i_word LD = 32'h80F0_A585;

    store_t exp_store [NUM_STORES];
    int     num_exp;
    int     store_idx;
    int     err_count = 0;
    store_t seen;
    store_t want;

    function automatic rv32i_word mask_bits(byte_mask m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic string test_name(int i);
        if (i < 10) return "arith";
        if (i < 16) return "store_align";
        if (i < 20) return "load_ext";
        return "control_flow";
    endfunction

    task automatic add_store(rv32i_word addr, rv32i_word data, byte_mask mbe);
        exp_store[num_exp] = '{addr: addr, data: data, mbe: mbe};
        num_exp = num_exp + 1;
    endtask

    initial begin
        num_exp = 0;
        add_store(32'h400, 32'hABCD_E000, 4'hF);
        add_store(32'h404, 32'd20 + 32'h1000, 4'hF);
        add_store(32'h408, A + B, 4'hF);
        add_store(32'h40C, A - B, 4'hF);
        // -7 is below 100 as a signed number but not as an unsigned one
        add_store(32'h410, 32'd1, 4'hF);
        add_store(32'h414, 32'd0, 4'hF);
        add_store(32'h418, A ^ B, 4'hF);
        add_store(32'h41C, {B[31], B[31:1]}, 4'hF);
        add_store(32'h420, B >> 28, 4'hF);
        add_store(32'h424, A << 4, 4'hF);
        for (int k = 0; k < 4; k++) begin
            add_store(32'h428, {24'h0, C[7:0]} << (8 * k), 4'b0001 << k);
        end
        add_store(32'h42C, {16'h0, C[15:0]}, 4'b0011);
        add_store(32'h42C, {C[15:0], 16'h0}, 4'b1100);
        add_store(32'h430, {{24{LD[15]}}, LD[15:8]}, 4'hF);
        add_store(32'h434, {24'h0, LD[15:8]}, 4'hF);
        add_store(32'h438, {{16{LD[31]}}, LD[31:16]}, 4'hF);
        add_store(32'h43C, {16'h0, LD[31:16]}, 4'hF);
        add_store(32'h440, A + B, 4'hF);
        // links of the jal at word 54 and the jalr at word 58
        add_store(32'h444, 32'd54 * 4 + 4, 4'hF);
        add_store(32'h448, 32'd58 * 4 + 4, 4'hF);
        add_store(32'h7FC, A, 4'hF);
    end

    assign seen = '{addr: data_addr, data: data_wdata & mask_bits(data_mbe), mbe: data_mbe};
    assign want = (store_idx < NUM_STORES) ? exp_store[store_idx] : '0;

    always @(posedge clk) begin
        if (!rst_n) begin
            store_idx <= 0;
        end else if (data_write && data_resp) begin
            store_idx <= store_idx + 1;
        end
    end

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (inst_addr == `RESET_PC) && !data_read && !data_write)
        else begin
            err_count = err_count + 1;
            $error("mismatch reset expected %h 0 0 actual %h %b %b", `RESET_PC,
                   $sampled(inst_addr), $sampled(data_read), $sampled(data_write));
        end

    store_check: assert property (@(posedge clk) disable iff (!rst_n)
        (data_write && data_resp) |-> (seen == want))
        else begin
            err_count = err_count + 1;
            $error("mismatch %s expected %h %h %h actual %h %h %h",
                   test_name($sampled(store_idx)),
                   $sampled(want.addr), $sampled(want.data), $sampled(want.mbe),
                   $sampled(seen.addr), $sampled(seen.data), $sampled(seen.mbe));
        end

    // a waiting request must not move
    inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (inst_read && !inst_resp) |=> $stable(inst_addr))
        else begin
            err_count = err_count + 1;
            $error("inst_addr changed while the fetch was waiting");
        end

    data_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ((data_read || data_write) && !data_resp) |=>
            ($stable(data_addr) && $stable(data_wdata) && $stable(data_mbe)))
        else begin
            err_count = err_count + 1;
            $error("data request changed while the access was waiting");
        end

endmodule

bind rv32i_core tb_props u_props (.*);

//--- tb_top.sv
`include "rv32i_config.svh"

module tb_top;
    import rv32i_pkg::*;

    localparam int        MEM_SIZE    = 1 << `MEM_ADDR_BITS;
    localparam rv32i_word MARKER_ADDR = 32'h7FC;
    localparam int        MAX_DELAY   = 3;

    logic      clk;
    logic      rst_n;
    rv32i_word inst_rdata;
    logic      inst_resp;
    rv32i_word inst_addr;
    logic      inst_read;
    rv32i_word data_rdata;
    logic      data_resp;
    rv32i_word data_addr;
    rv32i_word data_wdata;
    byte_mask  data_mbe;
    logic      data_read;
    logic      data_write;

    logic [7:0] mem [MEM_SIZE];
    rv32i_word  prog [$];
    logic       prog_ready = 1'b0;
    int         seed = 32'he7de_1743;
    rv32i_word  inst_last;
    int         inst_wait;
    int         data_wait;

    rv32i_core DUT (.*);

    function automatic rv32i_word enc_i(int imm, int rs1, int f3, int rd, rv32i_opcode op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic rv32i_word enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic rv32i_word enc_s(int imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OP_STORE};
    endfunction

    function automatic rv32i_word enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic rv32i_word enc_u(int imm, int rd, rv32i_opcode op);
        return {imm[19:0], rd[4:0], op};
    endfunction

    function automatic rv32i_word enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    task automatic add_nops(int n);
        repeat (n) begin
            prog.push_back(enc_i(0, 0, 0, 0, OP_IMM));
        end
    endtask

    task automatic add_squashed_stores();
        repeat (`SQUASH_DEPTH) begin
            prog.push_back(enc_s(64, 1, 10, 2));
        end
    endtask

    function automatic rv32i_word read_word(rv32i_word addr);
        int base;
        base = {addr[`MEM_ADDR_BITS-1:2], 2'b00};
        return {mem[base + 3], mem[base + 2], mem[base + 1], mem[base]};
    endfunction

    function automatic int draw_delay();
        return $random(seed) & MAX_DELAY;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // program of constants, ALU ops, stores, loads, then branches and jumps
    initial begin
        int res_regs [10];
        res_regs = '{3, 4, 5, 6, 7, 8, 9, 13, 14, 15};
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a] = 8'(a ^ (a >> 4) ^ 32'h5A);
        end
        prog.push_back(enc_i(100, 0, 0, 1, OP_IMM));
        prog.push_back(enc_i(-7, 0, 0, 2, OP_IMM));
        prog.push_back(enc_i(32'h400, 0, 0, 10, OP_IMM));
        prog.push_back(enc_i(32'h500, 0, 0, 11, OP_IMM));
        prog.push_back(enc_u(32'hABCDE, 3, OP_LUI));
        prog.push_back(enc_u(1, 4, OP_AUIPC));
        prog.push_back(enc_i(32'h7FC, 0, 0, 12, OP_IMM));
        prog.push_back(enc_u(32'h11223, 16, OP_LUI));
        add_nops(3);
        prog.push_back(enc_r(0, 2, 1, 0, 5));
        prog.push_back(enc_r(32, 2, 1, 0, 6));
        prog.push_back(enc_r(0, 1, 2, 2, 7));
        prog.push_back(enc_r(0, 1, 2, 3, 8));
        prog.push_back(enc_r(0, 2, 1, 4, 9));
        prog.push_back(enc_i(32'h401, 2, 5, 13, OP_IMM));
        prog.push_back(enc_i(28, 2, 5, 14, OP_IMM));
        prog.push_back(enc_i(4, 1, 1, 15, OP_IMM));
        prog.push_back(enc_i(32'h344, 16, 0, 16, OP_IMM));
        add_nops(3);
        for (int i = 0; i < 10; i++) begin
            prog.push_back(enc_s(4 * i, res_regs[i], 10, 2));
        end
        for (int i = 0; i < 4; i++) begin
            prog.push_back(enc_s(40 + i, 16, 10, 0));
        end
        prog.push_back(enc_s(44, 16, 10, 1));
        prog.push_back(enc_s(46, 16, 10, 1));
        prog.push_back(enc_i(1, 11, 0, 17, OP_LOAD));
        prog.push_back(enc_i(1, 11, 4, 18, OP_LOAD));
        prog.push_back(enc_i(2, 11, 1, 19, OP_LOAD));
        prog.push_back(enc_i(2, 11, 5, 20, OP_LOAD));
        add_nops(3);
        for (int i = 0; i < 4; i++) begin
            prog.push_back(enc_s(48 + 4 * i, 17 + i, 10, 2));
        end
        prog.push_back(enc_b(16, 1, 1, 0));
        add_squashed_stores();
        prog.push_back(enc_j(16, 21));
        add_squashed_stores();
        // bit 0 of the jalr target is set on purpose
        prog.push_back(enc_i(249, 0, 0, 22, OP_JALR));
        add_squashed_stores();
        prog.push_back(enc_b(16, 1, 1, 1));
        prog.push_back(enc_s(64, 5, 10, 2));
        prog.push_back(enc_s(68, 21, 10, 2));
        prog.push_back(enc_s(72, 22, 10, 2));
        prog.push_back(enc_s(0, 1, 12, 2));
        prog.push_back(enc_j(0, 0));
        for (int i = 0; i < prog.size(); i++) begin
            {mem[4 * i + 3], mem[4 * i + 2], mem[4 * i + 1], mem[4 * i]} = prog[i];
        end
        {mem['h503], mem['h502], mem['h501], mem['h500]} = 32'h80F0_A585;
        prog_ready = 1'b1;
    end

    // memory model answering after 0 to 3 cycles
    always @(negedge clk) begin
        if (!rst_n) begin
            inst_resp <= 1'b0;
            data_resp <= 1'b0;
            inst_last = 32'hFFFF_FFFF;
            inst_wait = 0;
            data_wait = draw_delay();
        end else begin
            if (inst_addr != inst_last) begin
                inst_last = inst_addr;
                inst_wait = draw_delay();
            end else if (inst_wait != 0) begin
                inst_wait = inst_wait - 1;
            end
            inst_resp  <= inst_read && (inst_wait == 0);
            inst_rdata <= read_word(inst_addr);
            if (data_resp) begin
                data_wait = draw_delay();
            end else if ((data_read || data_write) && data_wait != 0) begin
                data_wait = data_wait - 1;
            end
            data_resp <= 1'b0;
            if ((data_read || data_write) && data_wait == 0) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_write && data_mbe[b]) begin
                        mem[{data_addr[`MEM_ADDR_BITS-1:2], 2'(b)}] = data_wdata[8 * b +: 8];
                    end
                end
                data_rdata <= read_word(data_addr);
                data_resp  <= 1'b1;
            end
        end
    end

    initial begin
        rst_n      = 1'b0;
        inst_rdata = '0;
        inst_resp  = 1'b0;
        data_rdata = '0;
        data_resp  = 1'b0;
        wait (prog_ready);
        repeat (8) @(negedge clk);
        rst_n <= 1'b1;
        do begin
            @(posedge clk);
        end while (!(data_write && data_resp && data_addr == MARKER_ADDR));
        @(negedge clk);
        if (DUT.u_props.err_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertion errors were reported");
        end
    end

    initial begin
        wait (DUT.u_props.err_count != 0);
        $display("Test failed");
        $fatal(1, "an assertion failed");
    end

    initial begin
        wait (prog_ready);
        repeat (8 + prog.size() * (4 + MAX_DELAY) * 2) @(posedge clk);
        $display("Test failed");
        $fatal(1, "timeout, the final store never appeared");
    end

endmodule

//--- src.f
+incdir+.
rv32i_pkg.sv
control_unit.sv
regfile.sv
alu.sv
datapath.sv
rv32i_core.sv
tb_props.sv
tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST)) rv32i_config.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
